/* Makefile */
TOP = csr_unit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Errors found" sim.log; then echo "FAIL"; exit 1; fi
	@grep -q "No errors" sim.log || (echo "FAIL: run ended early"; exit 1)
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log

/* design/csr_decoder.sv */
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_decoder
    import csr_pkg::*;
    import priv_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  sys_insn_u            req_insn,
    input  logic [`CSR_XLEN-1:0] req_rs1,
    input  priv_e                priv,
    output csr_op_t              op
);

    csr_op_t op_d;
    logic    addr_ok;
    logic    is_csr;
    logic    rs1_zero;

    // Known machine-mode addresses
    always_comb begin
        case (req_insn.csr.addr)
            CSR_MSTATUS, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE: addr_ok = 1'b1;
            default: addr_ok = 1'b0;
        endcase
    end

    // A zero rs1 field makes set and clear read-only
    assign rs1_zero = (req_insn.csr.uimm == 5'd0);

    always_comb begin
        op_d      = '0;
        is_csr    = 1'b1;
        op_d.addr = req_insn.csr.addr;
        // Immediate forms have funct3 bit 2 set
        if (req_insn.csr.funct3[2]) begin
            op_d.operand = {{(`CSR_XLEN-5){1'b0}}, req_insn.csr.uimm};
        end else begin
            op_d.operand = req_rs1;
        end
        case (req_insn.csr.funct3)
            F3_CSRRW, F3_CSRRWI: begin
                op_d.kind  = KIND_WRITE;
                op_d.wr_en = 1'b1;
            end
            F3_CSRRS, F3_CSRRSI: begin
                op_d.kind  = KIND_SET;
                op_d.wr_en = !rs1_zero;
            end
            F3_CSRRC, F3_CSRRCI: begin
                op_d.kind  = KIND_CLEAR;
                op_d.wr_en = !rs1_zero;
            end
            F3_PRIV: begin
                is_csr = 1'b0;
                // MRET needs rs1 and rd both zero
                if (req_insn.sys.funct12 == F12_MRET && req_insn.sys.rs1 == 5'd0 &&
                    req_insn.sys.rd == 5'd0) begin
                    op_d.kind = KIND_MRET;
                end else begin
                    op_d.kind = KIND_ILLEGAL;
                end
            end
            default: begin
                is_csr    = 1'b0;
                op_d.kind = KIND_ILLEGAL;
            end
        endcase
        // Wrong opcode, user mode or unknown CSR all trap out as illegal
        if (req_insn.csr.opcode != OPC_SYSTEM || priv == PRIV_USER || (is_csr && !addr_ok)) begin
            op_d.kind  = KIND_ILLEGAL;
            op_d.wr_en = 1'b0;
        end
        op_d.valid = req_valid;
        if (!req_valid) begin
            op_d.kind  = KIND_NONE;
            op_d.wr_en = 1'b0;
        end
    end

    // One-deep buffer toward the register blocks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op <= '0;
        end else begin
            op <= op_d;
        end
    end

endmodule

/* design/csr_file.sv */
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_file
    import csr_pkg::*;
    import priv_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  csr_op_t              op,
    input  trap_t                trap,
    input  mstatus_t             mstatus,
    output mstatus_cmd_e         mst_cmd,
    output logic [`CSR_XLEN-1:0] mst_wdata,
    output csr_rsp_t             rsp,
    output redirect_t            redir
);

    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] old_val;
    logic [`CSR_XLEN-1:0] new_val;
    logic                 op_live;
    logic                 do_write;
    logic                 is_mret;

    // A trap in the same cycle swallows the op
    assign op_live  = op.valid && !trap.valid;
    assign do_write = op_live && op.wr_en;
    assign is_mret  = op_live && (op.kind == KIND_MRET);

    // Old value, already holding last cycle's write
    always_comb begin
        case (op.addr)
            CSR_MSTATUS:  old_val = mstatus;
            CSR_MTVEC:    old_val = mtvec;
            CSR_MSCRATCH: old_val = mscratch;
            CSR_MEPC:     old_val = mepc;
            CSR_MCAUSE:   old_val = mcause;
            default:      old_val = '0;
        endcase
    end

    // Read-modify-write
    always_comb begin
        case (op.kind)
            KIND_WRITE: new_val = op.operand;
            KIND_SET:   new_val = old_val | op.operand;
            KIND_CLEAR: new_val = old_val & ~op.operand;
            default:    new_val = old_val;
        endcase
    end

    // Trap wins over MRET, MRET over a write
    always_comb begin
        if (trap.valid) begin
            mst_cmd = MST_TRAP;
        end else if (is_mret) begin
            mst_cmd = MST_MRET;
        end else if (do_write && op.addr == CSR_MSTATUS) begin
            mst_cmd = MST_WRITE;
        end else begin
            mst_cmd = MST_HOLD;
        end
    end

    assign mst_wdata = new_val;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec    <= `MTVEC_RESET;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (trap.valid) begin
            // Word-aligned return address
            mepc   <= {trap.pc[`CSR_XLEN-1:2], 2'b00};
            mcause <= trap.cause;
        end else if (do_write) begin
            case (op.addr)
                CSR_MTVEC:    mtvec <= {new_val[`CSR_XLEN-1:2], 2'b00};
                CSR_MSCRATCH: mscratch <= new_val;
                CSR_MEPC:     mepc <= {new_val[`CSR_XLEN-1:2], 2'b00};
                CSR_MCAUSE:   mcause <= new_val;
                default:      mscratch <= mscratch;
            endcase
        end
    end

    // Response and redirect leave together, two cycles after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp   <= '0;
            redir <= '0;
        end else begin
            rsp.valid   <= op_live;
            rsp.illegal <= (op.kind == KIND_ILLEGAL);
            // Illegal ops return zero
            rsp.rdata   <= (op.kind == KIND_ILLEGAL) ? '0 : old_val;
            if (trap.valid) begin
                redir.valid <= 1'b1;
                redir.pc    <= mtvec;
            end else if (is_mret) begin
                redir.valid <= 1'b1;
                redir.pc    <= mepc;
            end else begin
                redir.valid <= 1'b0;
                redir.pc    <= redir.pc;
            end
        end
    end

endmodule

/* design/csr_macros.svh */
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// Data path width of the CSR unit
`define CSR_XLEN 32

// MIE set and MPP at machine mode out of reset
`define MSTATUS_RESET 32'h0000_1808

// Bits 0, 1, 3, 4, 5, 7, 8, 11 and 12 are writable
`define MSTATUS_WMASK 32'h0000_19BB

// Trap vector base after reset
`define MTVEC_RESET 32'h0000_0100

`endif

/* design/csr_pkg.sv */
package csr_pkg;

    // SYSTEM opcode and funct3 encodings
    localparam logic [6:0]  OPC_SYSTEM = 7'b111_0011;
    localparam logic [2:0]  F3_PRIV    = 3'b000;
    localparam logic [2:0]  F3_CSRRW   = 3'b001;
    localparam logic [2:0]  F3_CSRRS   = 3'b010;
    localparam logic [2:0]  F3_CSRRC   = 3'b011;
    localparam logic [2:0]  F3_CSRRWI  = 3'b101;
    localparam logic [2:0]  F3_CSRRSI  = 3'b110;
    localparam logic [2:0]  F3_CSRRCI  = 3'b111;
    localparam logic [11:0] F12_MRET   = 12'h302;

    // CSR view of a SYSTEM word, rs1 doubles as uimm
    typedef struct packed {
        logic [11:0] addr;
        logic [4:0]  uimm;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } csr_fmt_t;

    // Privileged view, funct12 picks MRET
    typedef struct packed {
        logic [11:0] funct12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } priv_fmt_t;

    typedef union packed {
        csr_fmt_t  csr;
        priv_fmt_t sys;
    } sys_insn_u;

    // Implemented machine-mode CSRs
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342
    } csr_addr_e;

    typedef enum logic [2:0] {
        KIND_NONE,
        KIND_WRITE,
        KIND_SET,
        KIND_CLEAR,
        KIND_MRET,
        KIND_ILLEGAL
    } csr_kind_e;

    // One decoded request, operand is rs1 or zero-extended uimm
    typedef struct packed {
        logic        valid;
        csr_kind_e   kind;
        logic [11:0] addr;
        logic [31:0] operand;
        logic        wr_en;
    } csr_op_t;

endpackage

/* design/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit
    import csr_pkg::*;
    import priv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  sys_insn_u   req_insn,
    input  logic [31:0] req_rs1,
    input  trap_t       trap,
    output csr_rsp_t    rsp,
    output redirect_t   redir,
    output priv_e       priv,
    output mstatus_t    mstatus
);

    // Decoded op, one cycle after the request
    csr_op_t      op;
    mstatus_cmd_e mst_cmd;
    logic [31:0]  mst_wdata;

    csr_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_insn  (req_insn),
        .req_rs1   (req_rs1),
        .priv      (priv),
        .op        (op)
    );

    // Owns command priority and the four plain CSRs
    csr_file u_csr_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .trap      (trap),
        .mstatus   (mstatus),
        .mst_cmd   (mst_cmd),
        .mst_wdata (mst_wdata),
        .rsp       (rsp),
        .redir     (redir)
    );

    mstatus_reg u_mstatus (
        .clk       (clk),
        .rst_n     (rst_n),
        .mst_cmd   (mst_cmd),
        .mst_wdata (mst_wdata),
        .priv      (priv),
        .mstatus   (mstatus)
    );

endmodule

/* design/mstatus_reg.sv */
`timescale 1ns/1ps
`include "csr_macros.svh"

module mstatus_reg
    import priv_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  mstatus_cmd_e         mst_cmd,
    input  logic [`CSR_XLEN-1:0] mst_wdata,
    output priv_e                priv,
    output mstatus_t             mstatus
);

    mstatus_t             mst_q;
    mstatus_t             mst_d;
    priv_e                priv_q;
    priv_e                priv_d;
    logic [`CSR_XLEN-1:0] wr_word;

    // Only implemented bits survive a write
    assign wr_word = mst_wdata & `MSTATUS_WMASK;

    always_comb begin
        mst_d  = mst_q;
        priv_d = priv_q;
        case (mst_cmd)
            MST_TRAP: begin
                // Stack MIE and the old mode, run handler in machine mode
                mst_d.mpie = mst_q.mie;
                mst_d.mie  = 1'b0;
                mst_d.mpp  = priv_q;
                priv_d     = PRIV_MACHINE;
            end
            MST_MRET: begin
                // Pop the stack, MPP falls to the lowest mode
                mst_d.mie  = mst_q.mpie;
                mst_d.mpie = 1'b1;
                priv_d     = mst_q.mpp;
                mst_d.mpp  = PRIV_USER;
            end
            MST_WRITE: begin
                mst_d = mstatus_t'(wr_word);
                // Supervisor and reserved MPP codes land in user mode
                if (wr_word[12:11] == 2'b11) begin
                    mst_d.mpp = PRIV_MACHINE;
                end else begin
                    mst_d.mpp = PRIV_USER;
                end
            end
            default: begin
                mst_d  = mst_q;
                priv_d = priv_q;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mst_q  <= mstatus_t'(`MSTATUS_RESET);
            priv_q <= PRIV_MACHINE;
        end else begin
            mst_q  <= mst_d;
            priv_q <= priv_d;
        end
    end

    assign mstatus = mst_q;
    assign priv    = priv_q;

endmodule

/* design/priv_pkg.sv */
package priv_pkg;

    // Only user and machine modes exist
    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    // Architectural mstatus layout, unimplemented fields read zero
    typedef struct packed {
        logic [18:0] rsv31_13;
        priv_e       mpp;
        logic [1:0]  rsv10_9;
        logic        spp;
        logic        mpie;
        logic        rsv6;
        logic        spie;
        logic        upie;
        logic        mie;
        logic        rsv2;
        logic        sie;
        logic        uie;
    } mstatus_t;

    // Synchronous exception entry
    typedef struct packed {
        logic        valid;
        logic [31:0] cause;
        logic [31:0] pc;
    } trap_t;

    // What mstatus does this cycle, chosen in the CSR file
    typedef enum logic [1:0] {
        MST_HOLD,
        MST_TRAP,
        MST_MRET,
        MST_WRITE
    } mstatus_cmd_e;

    // Fetch redirect on trap entry or MRET
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic [31:0] rdata;
    } csr_rsp_t;

endpackage

/* sim.f */
+incdir+design
design/csr_pkg.sv
design/priv_pkg.sv
design/csr_decoder.sv
design/mstatus_reg.sv
design/csr_file.sv
design/csr_unit.sv
test/csr_unit_props.sv
test/csr_unit_tb.sv

/* test/csr_unit_props.sv */
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_unit_props
    import priv_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      req_valid,
    input trap_t     trap,
    input csr_rsp_t  rsp,
    input redirect_t redir,
    input priv_e     priv,
    input mstatus_t  mstatus
);

    // Sampled request answers two edges later unless a trap swallows it
    rsp_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid ##1 !trap.valid |=> rsp.valid)
        else $error("response missing two edges after a request");

    // No response without a request two edges back
    rsp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.valid |-> $past(req_valid, 2))
        else $error("response without a matching request");

    rst_quiet: assert property (@(posedge clk)
        !rst_n |-> (!rsp.valid && !redir.valid))
        else $error("strobe high during reset");

    // Only user and machine modes can be held
    priv_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (priv == PRIV_USER || priv == PRIV_MACHINE))
        else $error("illegal privilege mode held");

    mst_unused_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((32'(mstatus) & ~`MSTATUS_WMASK) == 32'd0))
        else $error("unimplemented mstatus bits are set");

endmodule

/* test/csr_unit_tb.sv */
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_unit_tb
    import csr_pkg::*;
    import priv_pkg::*;
();

    localparam int          NUM_OPS    = 400;
    // At most 4 cycles per op, with a threefold margin plus reset and the directed part
    localparam int          MAX_CYCLES = NUM_OPS * 12 + 200;
    localparam logic [31:0] SEED       = 32'h7ca3_795b;
    localparam logic [31:0] MRET_INSN  = 32'h3020_0073;

    // Data is rdata for a response and the target pc for a redirect
    typedef struct packed {
        logic        illegal;
        logic [31:0] data;
        logic [1:0]  priv;
        logic [31:0] mstatus;
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    sys_insn_u   req_insn;
    logic [31:0] req_rs1;
    trap_t       trap;
    csr_rsp_t    rsp;
    redirect_t   redir;
    priv_e       priv;
    mstatus_t    mstatus;

    // Shadow copies of the architectural state
    logic [31:0] sh_mstatus;
    logic [31:0] sh_mtvec;
    logic [31:0] sh_mscratch;
    logic [31:0] sh_mepc;
    logic [31:0] sh_mcause;
    logic [1:0]  sh_priv;
    exp_t        rsp_q[$];
    exp_t        redir_q[$];
    int          cycles = 0;
    logic [31:0] seed_ret;

    csr_unit dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_insn  (req_insn),
        .req_rs1   (req_rs1),
        .trap      (trap),
        .rsp       (rsp),
        .redir     (redir),
        .priv      (priv),
        .mstatus   (mstatus)
    );

    bind csr_unit csr_unit_props u_props (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .trap      (trap),
        .rsp       (rsp),
        .redir     (redir),
        .priv      (priv),
        .mstatus   (mstatus)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    function automatic logic [31:0] csr_value(input logic [11:0] addr);
        case (addr)
            12'h300: return sh_mstatus;
            12'h305: return sh_mtvec;
            12'h340: return sh_mscratch;
            12'h341: return sh_mepc;
            12'h342: return sh_mcause;
            default: return 32'd0;
        endcase
    endfunction

    function automatic void csr_store(input logic [11:0] addr, input logic [31:0] val);
        logic [31:0] w;
        w = val & `MSTATUS_WMASK;
        // MPP codes 01 and 10 fall back to user
        w[12:11] = (w[12:11] == 2'b11) ? 2'b11 : 2'b00;
        case (addr)
            12'h300: sh_mstatus = w;
            12'h305: sh_mtvec = {val[31:2], 2'b00};
            12'h340: sh_mscratch = val;
            12'h341: sh_mepc = {val[31:2], 2'b00};
            default: sh_mcause = val;
        endcase
    endfunction

    // Reference for one request, applied in issue order
    function automatic void model_request(input logic [31:0] insn, input logic [31:0] rs1,
                                          output exp_t rsp_e, output logic has_redir,
                                          output exp_t redir_e);
        logic [11:0] addr;
        logic [4:0]  rs1f;
        logic [2:0]  f3;
        logic        is_mret;
        logic        illegal;
        logic [31:0] operand;
        logic [31:0] old;
        logic [31:0] nv;
        addr      = insn[31:20];
        rs1f      = insn[19:15];
        f3        = insn[14:12];
        is_mret   = (f3 == 3'd0) && (addr == 12'h302) && (rs1f == 5'd0) && (insn[11:7] == 5'd0);
        illegal   = (insn[6:0] != 7'h73) || (sh_priv == 2'b00) || (f3 == 3'b100) ||
                    (f3 == 3'd0 && !is_mret) ||
                    (f3 != 3'd0 && !(addr inside {12'h300, 12'h305, 12'h340, 12'h341, 12'h342}));
        // Immediate forms zero-extend the rs1 field
        operand   = f3[2] ? {27'd0, rs1f} : rs1;
        old       = csr_value(addr);
        rsp_e     = '0;
        redir_e   = '0;
        has_redir = 1'b0;
        if (illegal) begin
            rsp_e.illegal = 1'b1;
        end else if (is_mret) begin
            // Back to mepc, pop the enable stack, MPP drops to user
            has_redir         = 1'b1;
            redir_e.data      = sh_mepc;
            sh_mstatus[3]     = sh_mstatus[7];
            sh_mstatus[7]     = 1'b1;
            sh_priv           = sh_mstatus[12:11];
            sh_mstatus[12:11] = 2'b00;
        end else begin
            rsp_e.data = old;
            case (f3[1:0])
                2'b01:   nv = operand;
                2'b10:   nv = old | operand;
                default: nv = old & ~operand;
            endcase
            // Set or clear with a zero rs1 field only reads
            if (f3[1:0] == 2'b01 || rs1f != 5'd0) begin
                csr_store(addr, nv);
            end
        end
        rsp_e.priv      = sh_priv;
        rsp_e.mstatus   = sh_mstatus;
        redir_e.priv    = sh_priv;
        redir_e.mstatus = sh_mstatus;
    endfunction

    function automatic exp_t model_trap(input logic [31:0] cause, input logic [31:0] pc);
        exp_t r;
        r                 = '0;
        r.data            = sh_mtvec;
        sh_mepc           = {pc[31:2], 2'b00};
        sh_mcause         = cause;
        sh_mstatus[7]     = sh_mstatus[3];
        sh_mstatus[3]     = 1'b0;
        sh_mstatus[12:11] = sh_priv;
        sh_priv           = 2'b11;
        r.priv            = sh_priv;
        r.mstatus         = sh_mstatus;
        return r;
    endfunction

    task automatic drive_idle();
        @(posedge clk);
        req_valid <= 1'b0;
        trap      <= '0;
    endtask

    // Apply low means the request is meant to be swallowed by a trap
    task automatic drive_req(input logic [31:0] insn, input logic [31:0] rs1, input logic apply);
        exp_t e;
        exp_t r;
        logic has_redir;
        @(posedge clk);
        req_valid <= 1'b1;
        req_insn  <= insn;
        req_rs1   <= rs1;
        trap      <= '0;
        if (apply) begin
            model_request(insn, rs1, e, has_redir, r);
            rsp_q.push_back(e);
            if (has_redir) begin
                redir_q.push_back(r);
            end
        end
    endtask

    task automatic drive_trap(input logic [31:0] cause, input logic [31:0] pc);
        @(posedge clk);
        req_valid <= 1'b0;
        trap      <= {1'b1, cause, pc};
        redir_q.push_back(model_trap(cause, pc));
    endtask

    function automatic logic [31:0] random_csr_insn();
        logic [11:0] addr;
        logic [4:0]  rs1f;
        int unsigned pick;
        logic [31:0] r;
        r    = $urandom;
        pick = $urandom % 6;
        case ($urandom % 5)
            0:       addr = 12'h300;
            1:       addr = 12'h305;
            2:       addr = 12'h340;
            3:       addr = 12'h341;
            default: addr = 12'h342;
        endcase
        // Zero rs1 field about a quarter of the time
        rs1f = (r[1:0] == 2'b00) ? 5'd0 : r[6:2];
        return {addr, rs1f, (pick < 3) ? 3'(pick + 1) : 3'(pick + 2), r[11:7], 7'h73};
    endfunction

    function automatic logic [31:0] random_bad_insn();
        logic [31:0] base;
        logic [31:0] r;
        base = random_csr_insn();
        r    = $urandom;
        case (r % 4)
            // Low byte c4 never hits an implemented address
            0:       return {r[15:12], 8'hc4, base[19:0]};
            1:       return {base[31:15], 3'b100, base[11:0]};
            2:       return {base[31:7], 7'h33};
            default: return {12'h302, 5'd0, 3'd0, r[20:16] | 5'd1, 7'h73};
        endcase
    endfunction

    task automatic random_op();
        int unsigned pick;
        pick = $urandom % 100;
        if (pick < 55) begin
            drive_req(random_csr_insn(), $urandom, 1'b1);
            if ($urandom % 2 == 0) begin
                drive_idle();
            end
        end else if (pick < 65) begin
            drive_req(random_bad_insn(), $urandom, 1'b1);
        end else if (pick < 77) begin
            // Gap so the next request decodes with the new mode
            drive_req(MRET_INSN, 32'd0, 1'b1);
            drive_idle();
        end else if (pick < 90) begin
            drive_idle();
            drive_trap($urandom, $urandom);
        end else begin
            // Trap lands on the op's commit cycle
            drive_req(random_csr_insn(), $urandom, 1'b0);
            drive_trap($urandom, $urandom);
        end
    endtask

    // Compare outputs half a cycle after the edge
    always @(negedge clk) begin
        exp_t e;
        if (rst_n && rsp.valid) begin
            if (rsp_q.size() == 0) begin
                $display("Response at %0t with no request pending", $time);
                abort_run();
            end else begin
                e = rsp_q.pop_front();
                check_equal({31'd0, rsp.illegal}, {31'd0, e.illegal}, "rsp.illegal");
                check_equal(rsp.rdata, e.data, "rsp.rdata");
                check_equal({30'd0, priv}, {30'd0, e.priv}, "priv after response");
                check_equal(mstatus, e.mstatus, "mstatus after response");
            end
        end
        if (rst_n && redir.valid) begin
            if (redir_q.size() == 0) begin
                $display("Redirect at %0t with no trap or MRET pending", $time);
                abort_run();
            end else begin
                e = redir_q.pop_front();
                check_equal(redir.pc, e.data, "redir.pc");
                check_equal({30'd0, priv}, {30'd0, e.priv}, "priv after redirect");
                check_equal(mstatus, e.mstatus, "mstatus after redirect");
            end
        end
    end

    initial begin
        seed_ret    = $urandom(SEED);
        clk         = 1'b0;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_insn    = '0;
        req_rs1     = '0;
        trap        = '0;
        sh_mstatus  = `MSTATUS_RESET;
        sh_mtvec    = `MTVEC_RESET;
        sh_mscratch = 32'd0;
        sh_mepc     = 32'd0;
        sh_mcause   = 32'd0;
        sh_priv     = 2'b11;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        // Reset values read back through CSRRS with x0
        drive_req({12'h300, 5'd0, 3'b010, 5'd1, 7'h73}, 32'hffff_ffff, 1'b1);
        drive_req({12'h305, 5'd0, 3'b010, 5'd2, 7'h73}, 32'hffff_ffff, 1'b1);
        drive_idle();
        @(negedge clk);
        check_equal({30'd0, priv}, 32'd3, "priv after reset");
        // First MRET stays in machine mode, the second drops to user
        drive_req(MRET_INSN, 32'd0, 1'b1);
        drive_idle();
        drive_req(MRET_INSN, 32'd0, 1'b1);
        drive_idle();
        repeat (3) drive_req(random_csr_insn(), $urandom, 1'b1);
        drive_req(MRET_INSN, 32'd0, 1'b1);
        drive_idle();
        drive_trap(32'd2, 32'h0000_0a42);
        for (int i = 0; i < NUM_OPS; i++) begin
            random_op();
        end
        repeat (6) drive_idle();
        if (rsp_q.size() != 0 || redir_q.size() != 0) begin
            $display("Run ended with %0d responses and %0d redirects never seen",
                     rsp_q.size(), redir_q.size());
            abort_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule
